// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pmem_tb
FILELIST = tb.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SRCS     = $(shell grep -v '^+' $(FILELIST)) $(wildcard hw/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)

// ==== bench/pmem_props.sv ====
`include "pmem_consts.svh"

module pmem_props
  import pmem_pkg::*;
#(
  parameter int DELAY = 2,
  parameter int DEPTH = 64
) (
  input logic  clk,
  input logic  rst_n,
  input logic  write,
  input logic  read,
  input logic  fwrd,
  input padr_t padr
);

  fwrd_clear_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !fwrd)
    else $error("forward flag set in the first cycle after reset");

  // Fresh response only, the flag holds afterwards
  fwrd_needs_write: assert property (@(posedge clk) disable iff (!rst_n)
    $past(read, DELAY) && fwrd |-> $past(write, DELAY))
    else $error("forward flag without a write in the read cycle");

  padr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(padr) < DEPTH)
    else $error("response address beyond the array");

endmodule

bind bank_array pmem_props #(
  .DELAY (`PMEM_DRAM_DELAY),
  .DEPTH (`PMEM_NUMVBNK * `PMEM_NUMVROW)
) props_i (
  .clk   (clk),
  .rst_n (rst_n),
  .write (write),
  .read  (read),
  .fwrd  (rsp.fwrd),
  .padr  (rsp.padr)
);

bind shadow_array pmem_props #(
  .DELAY (`PMEM_SRAM_DELAY),
  .DEPTH (`PMEM_NUMVROW)
) props_i (
  .clk   (clk),
  .rst_n (rst_n),
  .write (write),
  .read  (read),
  .fwrd  (rsp.fwrd),
  .padr  (rsp.padr)
);

// ==== bench/pmem_tb.sv ====
`include "pmem_consts.svh"

module pmem_tb
  import pmem_pkg::*;
();

  localparam int PD     = `PMEM_DRAM_DELAY;
  localparam int SD     = `PMEM_SRAM_DELAY;
  localparam int LAT    = (PD > SD) ? PD : SD;
  localparam int SLOTS  = 64;
  localparam int PDEPTH = `PMEM_NUMVBNK * `PMEM_NUMVROW;

  // Everything driven in one cycle
  typedef struct packed {
    logic     p_we;
    pwr_req_t p_wr;
    logic     p_re;
    prd_req_t p_rd;
    logic     s_we;
    swr_req_t s_wr;
    logic     s1_re;
    row_t     s1_adr;
    logic     s2_re;
    row_t     s2_adr;
  } slot_t;

  logic     clk;
  logic     rst_n;
  logic     pwrite;
  pwr_req_t pwr_req;
  logic     pread;
  prd_req_t prd_req;
  prd_rsp_t prd_rsp;
  logic     swrite;
  swr_req_t swr_req;
  logic     sread1;
  row_t     srd_adr1;
  srd_rsp_t srd_rsp1;
  logic     sread2;
  row_t     srd_adr2;
  srd_rsp_t srd_rsp2;

  data_t    pmodel [PDEPTH];
  sword_t   smodel [`PMEM_NUMVROW];
  slot_t    slots [SLOTS];
  prd_rsp_t last_prsp;               // Primary response a dropped read leaves
  integer   seed;
  int       checks;
  int       errors;
  logic     timed_out;

  pmem_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pwrite   (pwrite),
    .pwr_req  (pwr_req),
    .pread    (pread),
    .prd_req  (prd_req),
    .prd_rsp  (prd_rsp),
    .swrite   (swrite),
    .swr_req  (swr_req),
    .sread1   (sread1),
    .srd_adr1 (srd_adr1),
    .srd_rsp1 (srd_rsp1),
    .sread2   (sread2),
    .srd_adr2 (srd_adr2),
    .srd_rsp2 (srd_rsp2)
  );

  always #20 clk = ~clk;

  function automatic data_t rand_data();
    return data_t'($random(seed));
  endfunction

  function automatic row_t rand_row();
    return row_t'($random(seed));
  endfunction

  function automatic sword_t rand_sword();
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    return r[$bits(sword_t)-1:0];
  endfunction

  function automatic padr_t bank_padr(input bank_t b, input row_t r);
    return padr_t'(int'(b) * `PMEM_NUMVROW + int'(r));
  endfunction

  function automatic srd_rsp_t shadow_expect(input slot_t s, input row_t adr);
    srd_rsp_t e;
    e.padr = padr_t'(adr);
    e.fwrd = s.s_we && s.s_wr.row == adr;
    e.word = e.fwrd ? s.s_wr.word : smodel[adr];
    return e;
  endfunction

  // Expected responses for one slot, then the slot's writes enter the model
  task automatic predict(input slot_t s, output prd_rsp_t pe, output srd_rsp_t se1,
                         output srd_rsp_t se2);
    logic pw_ok;
    pw_ok = s.p_we && int'(s.p_wr.bank) < `PMEM_NUMVBNK;
    pe    = last_prsp;
    if (s.p_re && int'(s.p_rd.bank) < `PMEM_NUMVBNK) begin
      pe.padr   = bank_padr(s.p_rd.bank, s.p_rd.row);
      pe.fwrd   = pw_ok && s.p_wr.bank == s.p_rd.bank && s.p_wr.row == s.p_rd.row;
      pe.data   = pe.fwrd ? s.p_wr.data : pmodel[pe.padr];
      last_prsp = pe;
    end
    se1 = shadow_expect(s, s.s1_adr);
    se2 = shadow_expect(s, s.s2_adr);
    if (pw_ok) begin
      pmodel[bank_padr(s.p_wr.bank, s.p_wr.row)] = s.p_wr.data;
    end
    if (s.s_we) begin
      smodel[s.s_wr.row] = s.s_wr.word;
    end
  endtask

  task automatic check_prd(input string name, input prd_rsp_t exp);
    checks++;
    if (prd_rsp !== exp) begin
      errors++;
      $display("error %s primary expected %h actual %h", name, exp, prd_rsp);
    end
  endtask

  task automatic check_srd(input string name, input int port, input srd_rsp_t exp,
                           input srd_rsp_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %s shadow port %0d expected %h actual %h", name, port, exp, act);
    end
  endtask

  task automatic clear_slots();
    for (int i = 0; i < SLOTS; i++) begin
      slots[i] = '0;
    end
  endtask

  // One slot per cycle, each response checked exactly its latency later
  task automatic run_slots(input string name, input int n);
    prd_rsp_t p_exp [SLOTS];
    srd_rsp_t s1_exp [SLOTS];
    srd_rsp_t s2_exp [SLOTS];
    slot_t    s;
    for (int k = 0; k < n + LAT; k++) begin
      @(posedge clk);
      if (k < n) begin
        s = slots[k];
        predict(s, p_exp[k], s1_exp[k], s2_exp[k]);
      end else begin
        s = '0;
      end
      pwrite   <= s.p_we;
      pwr_req  <= s.p_wr;
      pread    <= s.p_re;
      prd_req  <= s.p_rd;
      swrite   <= s.s_we;
      swr_req  <= s.s_wr;
      sread1   <= s.s1_re;
      srd_adr1 <= s.s1_adr;
      sread2   <= s.s2_re;
      srd_adr2 <= s.s2_adr;
      @(negedge clk);
      if (k >= PD && k - PD < n) begin
        if (slots[k-PD].p_re) begin
          check_prd(name, p_exp[k-PD]);
        end
      end
      if (k >= SD && k - SD < n) begin
        if (slots[k-SD].s1_re) begin
          check_srd(name, 1, s1_exp[k-SD], srd_rsp1);
        end
        if (slots[k-SD].s2_re) begin
          check_srd(name, 2, s2_exp[k-SD], srd_rsp2);
        end
      end
    end
  endtask

  task automatic wait_reset_release();
    int cnt;
    cnt = 0;
    while (cnt < 100 && !(rst_n === 1'b1 && prd_rsp === '0 && srd_rsp1 === '0 &&
                          srd_rsp2 === '0)) begin
      @(negedge clk);
      cnt++;
    end
    if (cnt >= 100) begin
      errors++;
      timed_out = 1'b1;
      $display("reset release with clear responses not seen within 100 cycles");
    end
  endtask

  // Memories are not reset, so every location gets a known word first
  task automatic prefill();
    for (int b = 0; b < `PMEM_NUMVBNK; b++) begin
      clear_slots();
      for (int r = 0; r < `PMEM_NUMVROW; r++) begin
        slots[r].p_we = 1'b1;
        slots[r].p_wr = '{bank: bank_t'(b), row: row_t'(r), data: rand_data()};
        slots[r].s_we = 1'b1;
        slots[r].s_wr = '{row: row_t'(r), word: rand_sword()};
      end
      run_slots("prefill", `PMEM_NUMVROW);
    end
  endtask

  task automatic primary_write_read();
    clear_slots();
    for (int i = 0; i < 12; i++) begin
      slots[i].p_we = 1'b1;
      slots[i].p_wr = '{bank: bank_t'(i % `PMEM_NUMVBNK), row: rand_row(), data: rand_data()};
    end
    run_slots("primary_write", 12);
    for (int i = 0; i < 12; i++) begin
      slots[i].p_we = 1'b0;
      slots[i].p_re = 1'b1;
      slots[i].p_rd = '{bank: slots[i].p_wr.bank, row: slots[i].p_wr.row};
    end
    run_slots("primary_read", 12);
  endtask

  task automatic missing_banks();
    row_t r;
    r = rand_row();
    clear_slots();
    slots[0].p_re = 1'b1;
    slots[0].p_rd = '{bank: bank_t'(2), row: r};
    slots[1].p_we = 1'b1;
    slots[1].p_wr = '{bank: bank_t'(6), row: r, data: rand_data()};
    slots[2].p_we = 1'b1;
    slots[2].p_wr = '{bank: bank_t'(7), row: r, data: rand_data()};
    slots[3].p_re = 1'b1;
    slots[3].p_rd = '{bank: bank_t'(6), row: r};
    slots[4]      = slots[2];        // Write and read bank 7 together
    slots[4].p_re = 1'b1;
    slots[4].p_rd = '{bank: bank_t'(7), row: r};
    for (int b = 0; b < `PMEM_NUMVBNK; b++) begin
      slots[5+b].p_re = 1'b1;
      slots[5+b].p_rd = '{bank: bank_t'(b), row: r};
    end
    slots[11] = slots[3];
    run_slots("missing_banks", 12);
  endtask

  task automatic forwarding();
    row_t r;
    r = rand_row();
    clear_slots();
    slots[0].p_we   = 1'b1;
    slots[0].p_wr   = '{bank: bank_t'(3), row: r, data: rand_data()};
    slots[0].p_re   = 1'b1;
    slots[0].p_rd   = '{bank: bank_t'(3), row: r};
    slots[0].s_we   = 1'b1;
    slots[0].s_wr   = '{row: r, word: rand_sword()};
    slots[0].s1_re  = 1'b1;
    slots[0].s1_adr = r;
    slots[0].s2_re  = 1'b1;
    slots[0].s2_adr = r;
    slots[1]        = slots[0];
    slots[1].p_we   = 1'b0;
    slots[1].s_we   = 1'b0;
    slots[2]        = slots[1];
    slots[2].s_we   = 1'b1;
    slots[2].s_wr   = '{row: r + row_t'(1), word: rand_sword()};  // Neighbour row, no hit
    run_slots("forwarding", 3);
  endtask

  task automatic shadow_duplication();
    row_t a;
    row_t b;
    a = rand_row();
    b = a ^ row_t'(5);
    clear_slots();
    slots[0].s_we = 1'b1;
    slots[0].s_wr = '{row: a, word: rand_sword()};
    slots[1].s_we = 1'b1;
    slots[1].s_wr = '{row: b, word: rand_sword()};
    for (int i = 2; i < 5; i++) begin
      slots[i].s1_re = 1'b1;
      slots[i].s2_re = 1'b1;
    end
    slots[2].s1_adr = a;
    slots[2].s2_adr = b;
    slots[3].s1_adr = a;
    slots[3].s2_adr = a;
    slots[4].s1_adr = b;
    slots[4].s2_adr = a;
    run_slots("shadow_duplication", 5);
  endtask

  task automatic pipelined_reads();
    clear_slots();
    for (int i = 0; i < 16; i++) begin
      slots[i].p_re   = 1'b1;
      slots[i].p_rd   = '{bank: bank_t'(i % `PMEM_NUMVBNK), row: rand_row()};
      slots[i].s1_re  = 1'b1;
      slots[i].s1_adr = rand_row();
      slots[i].s2_re  = 1'b1;
      slots[i].s2_adr = rand_row();
    end
    run_slots("pipelined_reads", 16);
  endtask

  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    pwrite    = 1'b0;
    pwr_req   = '0;
    pread     = 1'b0;
    prd_req   = '0;
    swrite    = 1'b0;
    swr_req   = '0;
    sread1    = 1'b0;
    srd_adr1  = '0;
    sread2    = 1'b0;
    srd_adr2  = '0;
    seed      = 32'h1a02;
    checks    = 0;
    errors    = 0;
    timed_out = 1'b0;
    last_prsp = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    wait_reset_release();
    if (!timed_out) begin
      prefill();
      primary_write_read();
      missing_banks();
      forwarding();
      shadow_duplication();
      pipelined_reads();
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/bank_array.sv ====
`include "pmem_consts.svh"

module bank_array
  import pmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     write,
  input  pwr_req_t wr,
  input  logic     read,
  input  prd_req_t rd,
  output prd_rsp_t rsp
);

  localparam int DELAY = `PMEM_DRAM_DELAY;
  localparam int DEPTH = `PMEM_NUMVBNK * `PMEM_NUMVROW;

  data_t            mem [DEPTH];

  padr_t            wr_padr;
  padr_t            rd_padr;
  prd_rsp_t         rd_now;               // Result formed in the strobe cycle

  prd_rsp_t         pipe_q [DELAY-1];
  logic [DELAY-2:0] vld_q;

  function automatic padr_t to_padr(input bank_t bank, input row_t row);
    return padr_t'(bank) * padr_t'(`PMEM_NUMVROW) + padr_t'(row);
  endfunction

  always_comb begin
    wr_padr     = to_padr(wr.bank, wr.row);
    rd_padr     = to_padr(rd.bank, rd.row);
    rd_now.padr = rd_padr;
    rd_now.fwrd = write && (wr_padr == rd_padr);  // Same-cycle hit
    rd_now.data = rd_now.fwrd ? wr.data : mem[rd_padr];
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr_padr] <= wr.data;
    end
  end

  // Valid bit per stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= read;
      for (int i = 1; i < DELAY-1; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // Stages advance only with a valid read
  always_ff @(posedge clk) begin
    if (read) begin
      pipe_q[0] <= rd_now;
    end
    for (int i = 1; i < DELAY-1; i++) begin
      if (vld_q[i-1]) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp <= '0;
    end else if (vld_q[DELAY-2]) begin
      rsp <= pipe_q[DELAY-2];             // Holds until next read lands
    end
  end

endmodule

// ==== hw/pmem_consts.svh ====
`ifndef PMEM_CONSTS_SVH
`define PMEM_CONSTS_SVH

// Primary word and address widths
`define PMEM_WIDTH        32
`define PMEM_BITVBNK      3
`define PMEM_NUMVBNK      6
`define PMEM_BITVROW      6
`define PMEM_NUMVROW      64
`define PMEM_BITPADR      9

// Shadow word metadata, reserved check field kept as payload
`define PMEM_ECCBITS      4
`define PMEM_SDOUT_WIDTH  (2*(`PMEM_BITVBNK+1)+`PMEM_ECCBITS)

// Read latencies in cycles, both arrays assume at least 2
`define PMEM_DRAM_DELAY   2
`define PMEM_SRAM_DELAY   2

`endif

// ==== hw/pmem_pkg.sv ====
`include "pmem_consts.svh"

package pmem_pkg;

  typedef logic [`PMEM_WIDTH-1:0]                   data_t;
  typedef logic [`PMEM_BITVBNK-1:0]                 bank_t;
  typedef logic [`PMEM_BITVROW-1:0]                 row_t;
  typedef logic [`PMEM_BITPADR-1:0]                 padr_t;
  typedef logic [`PMEM_SDOUT_WIDTH+`PMEM_WIDTH-1:0] sword_t;  // Metadata over data

  typedef struct packed {
    bank_t bank;
    row_t  row;
    data_t data;
  } pwr_req_t;

  typedef struct packed {
    bank_t bank;
    row_t  row;
  } prd_req_t;

  typedef struct packed {
    data_t data;
    logic  fwrd;
    padr_t padr;
  } prd_rsp_t;

  typedef struct packed {
    row_t   row;
    sword_t word;
  } swr_req_t;

  typedef struct packed {
    sword_t word;
    logic   fwrd;
    padr_t  padr;
  } srd_rsp_t;

endpackage

// ==== hw/pmem_port_mux.sv ====
`include "pmem_consts.svh"

module pmem_port_mux
  import pmem_pkg::*;
(
  // Primary client port
  input  logic           pwrite,
  input  pwr_req_t       pwr_req,
  input  logic           pread,
  input  prd_req_t       prd_req,
  output prd_rsp_t       prd_rsp,

  // Shadow client ports
  input  logic           swrite,
  input  swr_req_t       swr_req,
  input  logic           sread1,
  input  row_t           srd_adr1,
  output srd_rsp_t       srd_rsp1,
  input  logic           sread2,
  input  row_t           srd_adr2,
  output srd_rsp_t       srd_rsp2,

  // Bank array side
  output logic           bk_write,
  output pwr_req_t       bk_wr,
  output logic           bk_read,
  output prd_req_t       bk_rd,
  input  prd_rsp_t       bk_rsp,

  // Shadow copies, index 0 serves port 1
  output logic     [1:0] sh_write,
  output swr_req_t       sh_wr,
  output logic     [1:0] sh_read,
  output row_t     [1:0] sh_adr,
  input  srd_rsp_t [1:0] sh_rsp
);

  logic pwr_in_range;
  logic prd_in_range;

  // Only banks below the populated count exist
  assign pwr_in_range = int'(pwr_req.bank) < `PMEM_NUMVBNK;
  assign prd_in_range = int'(prd_req.bank) < `PMEM_NUMVBNK;

  assign bk_write = pwrite && pwr_in_range;  // Dropped when bank missing
  assign bk_wr    = pwr_req;

  assign bk_read  = pread && prd_in_range;   // No response for missing bank
  assign bk_rd    = prd_req;

  assign prd_rsp  = bk_rsp;

  // Every shadow write lands in both copies
  assign sh_write = {2{swrite}};
  assign sh_wr    = swr_req;

  assign sh_read  = {sread2, sread1};
  assign sh_adr   = {srd_adr2, srd_adr1};

  assign srd_rsp1 = sh_rsp[0];
  assign srd_rsp2 = sh_rsp[1];

endmodule

// ==== hw/pmem_top.sv ====
module pmem_top
  import pmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,

  input  logic     pwrite,
  input  pwr_req_t pwr_req,
  input  logic     pread,
  input  prd_req_t prd_req,
  output prd_rsp_t prd_rsp,

  input  logic     swrite,
  input  swr_req_t swr_req,
  input  logic     sread1,
  input  row_t     srd_adr1,
  output srd_rsp_t srd_rsp1,
  input  logic     sread2,
  input  row_t     srd_adr2,
  output srd_rsp_t srd_rsp2
);

  logic           bk_write;
  logic           bk_read;
  pwr_req_t       bk_wr;
  prd_req_t       bk_rd;
  prd_rsp_t       bk_rsp;

  logic     [1:0] sh_write;
  logic     [1:0] sh_read;
  swr_req_t       sh_wr;
  row_t     [1:0] sh_adr;
  srd_rsp_t [1:0] sh_rsp;

  pmem_port_mux mux_i (
    .pwrite   (pwrite),
    .pwr_req  (pwr_req),
    .pread    (pread),
    .prd_req  (prd_req),
    .prd_rsp  (prd_rsp),
    .swrite   (swrite),
    .swr_req  (swr_req),
    .sread1   (sread1),
    .srd_adr1 (srd_adr1),
    .srd_rsp1 (srd_rsp1),
    .sread2   (sread2),
    .srd_adr2 (srd_adr2),
    .srd_rsp2 (srd_rsp2),
    .bk_write (bk_write),
    .bk_wr    (bk_wr),
    .bk_read  (bk_read),
    .bk_rd    (bk_rd),
    .bk_rsp   (bk_rsp),
    .sh_write (sh_write),
    .sh_wr    (sh_wr),
    .sh_read  (sh_read),
    .sh_adr   (sh_adr),
    .sh_rsp   (sh_rsp)
  );

  bank_array bank_i (
    .clk   (clk),
    .rst_n (rst_n),
    .write (bk_write),
    .wr    (bk_wr),
    .read  (bk_read),
    .rd    (bk_rd),
    .rsp   (bk_rsp)
  );

  // Copy 0 serves read port 1
  shadow_array sh0_i (
    .clk   (clk),
    .rst_n (rst_n),
    .write (sh_write[0]),
    .wr    (sh_wr),
    .read  (sh_read[0]),
    .adr   (sh_adr[0]),
    .rsp   (sh_rsp[0])
  );

  shadow_array sh1_i (
    .clk   (clk),
    .rst_n (rst_n),
    .write (sh_write[1]),
    .wr    (sh_wr),
    .read  (sh_read[1]),
    .adr   (sh_adr[1]),
    .rsp   (sh_rsp[1])
  );

endmodule

// ==== hw/shadow_array.sv ====
`include "pmem_consts.svh"

module shadow_array
  import pmem_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     write,
  input  swr_req_t wr,
  input  logic     read,
  input  row_t     adr,
  output srd_rsp_t rsp
);

  localparam int DELAY = `PMEM_SRAM_DELAY;

  sword_t           mem [`PMEM_NUMVROW];

  srd_rsp_t         rd_now;
  srd_rsp_t         pipe_q [DELAY-1];
  logic [DELAY-2:0] vld_q;

  // Row doubles as physical address
  always_comb begin
    rd_now.padr = padr_t'(adr);
    rd_now.fwrd = write && (wr.row == adr);
    rd_now.word = rd_now.fwrd ? wr.word : mem[adr];
  end

  always_ff @(posedge clk) begin
    if (write) begin
      mem[wr.row] <= wr.word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= read;
      for (int i = 1; i < DELAY-1; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      pipe_q[0] <= rd_now;
    end
    for (int i = 1; i < DELAY-1; i++) begin
      if (vld_q[i-1]) begin
        pipe_q[i] <= pipe_q[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp <= '0;
    end else if (vld_q[DELAY-2]) begin
      rsp <= pipe_q[DELAY-2];
    end
  end

endmodule

// ==== tb.f ====
+incdir+hw
hw/pmem_pkg.sv
hw/pmem_port_mux.sv
hw/bank_array.sv
hw/shadow_array.sv
hw/pmem_top.sv
bench/pmem_props.sv
bench/pmem_tb.sv
